/* verilog/ca_rx_align_pkg.sv */
// Aligner localparams, vector typedefs, pattern and status structs, state enum
`default_nettype none

package ca_rx_align_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_CHANNELS     = 2;   // Lanes in the link
  localparam int BITS_PER_CHANNEL = 80;  // One word per lane per cycle
  localparam int WORD_BITS        = 40;  // Width of one strobe word
  localparam int NUM_WORDS        = 8;   // Word positions in the select
  localparam int WD_IDX_WIDTH     = $clog2(NUM_WORDS);
  localparam int FIFO_AD_WIDTH    = 4;
  localparam int FIFO_DEPTH       = 1 << FIFO_AD_WIDTH;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [BITS_PER_CHANNEL-1:0] ch_data_t;
  typedef logic [NUM_WORDS-1:0]        wd_sel_t;   // One-hot word select
  typedef logic [WORD_BITS-1:0]        bit_sel_t;  // One-hot bit select
  typedef logic [WD_IDX_WIDTH-1:0]     wd_idx_t;
  typedef logic [8:0]                  stb_loc_t;  // Strobe bit location
  typedef logic [2:0]                  rd_dly_t;
  typedef logic [FIFO_AD_WIDTH-1:0]    fifo_ptr_t;
  typedef logic [FIFO_AD_WIDTH:0]      fifo_cnt_t; // Holds 0 to FIFO_DEPTH

  // Decoded strobe position, shared by all lanes
  typedef struct packed {
    wd_idx_t  word_idx;
    bit_sel_t bit_mask;
  } stb_pattern_t;

  // Per-lane report to the controller
  typedef struct packed {
    logic first_stb;  // Sticky, lane has seen its strobe
    logic overflow;   // One-cycle pulse, write refused
  } lane_status_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_ONLINE,
    RX_ALIGNED,
    RX_ERR,
    RX_DONE
  } rx_state_t;

endpackage

`default_nettype wire

/* verilog/ca_rx_align_fifo.sv */
// Single-clock lane FIFO with overflow pulse, full and empty flags and registered read data
`timescale 1ns/1ns
`default_nettype none

module ca_rx_align_fifo
(
  input  wire                             com_clk,
  input  wire                             rst_com_n,
  input  wire                             clear,
  input  wire                             push,
  input  wire                             pop,
  input  wire ca_rx_align_pkg::ch_data_t  din,
  output ca_rx_align_pkg::ch_data_t       dout,
  output logic                            overflow,
  output logic                            full,
  output logic                            empty
);

  ca_rx_align_pkg::ch_data_t mem [ca_rx_align_pkg::FIFO_DEPTH];
  ca_rx_align_pkg::fifo_ptr_t wr_ptr;
  ca_rx_align_pkg::fifo_ptr_t rd_ptr;
  ca_rx_align_pkg::fifo_cnt_t count;
  logic                       push_ok;
  logic                       pop_ok;

  assign full     = count == ca_rx_align_pkg::fifo_cnt_t'(ca_rx_align_pkg::FIFO_DEPTH);
  assign empty    = count == '0;
  assign push_ok  = push && !full;
  assign pop_ok   = pop && !empty;    // Pop on empty is ignored
  assign overflow = push && full;     // Word is dropped

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= din;
  end

  // Head word shows the cycle after a pop, held otherwise
  always_ff @(posedge com_clk)
  begin
    if (pop_ok)
      dout <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

/* verilog/ca_rx_lane.sv */
// Per-lane strobe detect, sticky write enable and first-strobe flag around the lane FIFO
`timescale 1ns/1ns
`default_nettype none

module ca_rx_lane
(
  input  wire                                 com_clk,
  input  wire                                 rst_com_n,
  input  wire                                 online,
  input  wire ca_rx_align_pkg::stb_pattern_t  stb_pattern,
  input  wire                                 fifo_pop,
  input  wire ca_rx_align_pkg::ch_data_t      rx_din,
  output ca_rx_align_pkg::ch_data_t           rx_dout,
  output ca_rx_align_pkg::lane_status_t       status,
  output logic                                fifo_full,
  output logic                                fifo_empty
);

  // Lane word padded out to all eight strobe word positions
  logic [ca_rx_align_pkg::NUM_WORDS*ca_rx_align_pkg::WORD_BITS-1:0] din_ext;
  ca_rx_align_pkg::bit_sel_t stb_word;
  logic                      stb_hit;
  logic                      stb_det;    // Registered strobe detect
  logic                      wr_en;      // Sticky after first strobe
  logic                      first_stb;

  always_comb
  begin
    din_ext = '0;
    din_ext[ca_rx_align_pkg::BITS_PER_CHANNEL-1:0] = rx_din;
  end

  assign stb_word = din_ext[stb_pattern.word_idx * ca_rx_align_pkg::WORD_BITS +:
                            ca_rx_align_pkg::WORD_BITS];
  assign stb_hit  = |(stb_word & stb_pattern.bit_mask);

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      stb_det   <= 1'b0;
      wr_en     <= 1'b0;
      first_stb <= 1'b0;
    end
    else if (!online)
    begin
      stb_det   <= 1'b0;   // Lane restarts from scratch
      wr_en     <= 1'b0;
      first_stb <= 1'b0;
    end
    else
    begin
      stb_det   <= stb_hit;
      wr_en     <= wr_en | stb_hit;        // Word after the strobe is first
      first_stb <= first_stb | stb_det;
    end
  end

  assign status.first_stb = first_stb;

  ca_rx_align_fifo fifo_i (
    .com_clk   (com_clk),
    .rst_com_n (rst_com_n),
    .clear     (!online),
    .push      (wr_en),
    .pop       (fifo_pop),
    .din       (rx_din),
    .dout      (rx_dout),
    .overflow  (status.overflow),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

endmodule

`default_nettype wire

/* verilog/ca_rx_stb_sel.sv */
// Strobe select decoder with coding and position error flags
`timescale 1ns/1ns
`default_nettype none

module ca_rx_stb_sel
(
  input  wire ca_rx_align_pkg::wd_sel_t      rx_stb_wd_sel,
  input  wire ca_rx_align_pkg::bit_sel_t     rx_stb_bit_sel,
  output ca_rx_align_pkg::stb_pattern_t      stb_pattern,
  output logic                               rx_stb_pos_coding_err,
  output logic                               rx_stb_pos_err
);

  ca_rx_align_pkg::wd_idx_t  word_idx;
  ca_rx_align_pkg::stb_loc_t stb_loc;
  logic [5:0]                bit_pos;   // Highest set bit of the bit select
  logic [3:0]                wd_ones;
  logic [5:0]                bit_ones;

  // Lowest set word bit wins, none set gives word 0
  always_comb
  begin
    word_idx = '0;
    wd_ones  = '0;
    for (int w = ca_rx_align_pkg::NUM_WORDS - 1; w >= 0; w--)
    begin
      if (rx_stb_wd_sel[w])
        word_idx = ca_rx_align_pkg::wd_idx_t'(w);
      wd_ones = wd_ones + {3'b000, rx_stb_wd_sel[w]};
    end
  end

  always_comb
  begin
    bit_pos  = '0;
    bit_ones = '0;
    for (int b = 0; b < ca_rx_align_pkg::WORD_BITS; b++)
    begin
      if (rx_stb_bit_sel[b])
        bit_pos = 6'(b);  // Last hit is the highest
      bit_ones = bit_ones + {5'b00000, rx_stb_bit_sel[b]};
    end
  end

  assign stb_loc = ca_rx_align_pkg::stb_loc_t'(word_idx * ca_rx_align_pkg::WORD_BITS
                                                + bit_pos);

  assign stb_pattern.word_idx = word_idx;
  assign stb_pattern.bit_mask = rx_stb_bit_sel;

  // Exactly one bit expected in each select
  assign rx_stb_pos_coding_err = (wd_ones != 4'd1) || (bit_ones != 6'd1);
  assign rx_stb_pos_err        = stb_loc > ca_rx_align_pkg::BITS_PER_CHANNEL;

endmodule

`default_nettype wire

/* verilog/ca_rx_align_ctrl.sv */
// Alignment FSM, read delay counter, common FIFO pop, done and error outputs
`timescale 1ns/1ns
`default_nettype none

module ca_rx_align_ctrl
(
  input  wire                                 com_clk,
  input  wire                                 rst_com_n,
  input  wire                                 rx_online,
  input  wire ca_rx_align_pkg::rd_dly_t       rden_dly,
  input  wire ca_rx_align_pkg::lane_status_t [ca_rx_align_pkg::NUM_CHANNELS-1:0] lane_status,
  output logic                                online,
  output logic                                fifo_pop,
  output logic                                align_done,
  output logic                                align_err
);

  ca_rx_align_pkg::rx_state_t rx_state;
  ca_rx_align_pkg::rx_state_t next_state;
  ca_rx_align_pkg::rd_dly_t   rd_dly;
  logic                       rx_online_del;
  logic                       all_first;   // Every lane has its strobe
  logic                       any_ovf;

  always_comb
  begin
    all_first = 1'b1;
    any_ovf   = 1'b0;
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
    begin
      all_first = all_first & lane_status[i].first_stb;
      any_ovf   = any_ovf | lane_status[i].overflow;
    end
  end

  assign online   = rx_online;
  assign fifo_pop = all_first && (rd_dly == '0);  // All lanes pop together

  //////////////////////////////////////////////////////////////////////
  // Read delay and registered outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_online_del <= 1'b0;
      rd_dly        <= '0;
      align_done    <= 1'b0;
      align_err     <= 1'b0;
    end
    else
    begin
      rx_online_del <= rx_online;
      if (rx_online && !rx_online_del)
        rd_dly <= rden_dly;              // Load on rising edge
      else if (all_first && (rd_dly != '0))
        rd_dly <= rd_dly - 1'b1;
      align_done <= rx_state == ca_rx_align_pkg::RX_DONE;
      align_err  <= rx_state == ca_rx_align_pkg::RX_ERR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
      rx_state <= ca_rx_align_pkg::RX_IDLE;
    else
      rx_state <= next_state;
  end

  always_comb
  begin
    next_state = rx_state;
    case (rx_state)
      ca_rx_align_pkg::RX_IDLE:
        if (rx_online)
          next_state = ca_rx_align_pkg::RX_ONLINE;
      ca_rx_align_pkg::RX_ONLINE:
        if (any_ovf)
          next_state = ca_rx_align_pkg::RX_ERR;   // Overflow wins over alignment
        else if (all_first)
          next_state = ca_rx_align_pkg::RX_ALIGNED;
      ca_rx_align_pkg::RX_ALIGNED:
        if (rd_dly == '0)
          next_state = ca_rx_align_pkg::RX_DONE;
      ca_rx_align_pkg::RX_ERR,
      ca_rx_align_pkg::RX_DONE:
        next_state = rx_state;
      default:
        next_state = ca_rx_align_pkg::RX_IDLE;
    endcase
    // Leaving online always returns to idle
    if (!rx_online)
      next_state = ca_rx_align_pkg::RX_IDLE;
  end

endmodule

`default_nettype wire

/* verilog/ca_rx_align.sv */
// Aligner top with select decoder, lane generate loop and controller
`timescale 1ns/1ns
`default_nettype none

module ca_rx_align
(
  input  wire                              com_clk,
  input  wire                              rst_com_n,
  input  wire                              rx_online,
  input  wire ca_rx_align_pkg::rd_dly_t    rden_dly,
  input  wire ca_rx_align_pkg::wd_sel_t    rx_stb_wd_sel,
  input  wire ca_rx_align_pkg::bit_sel_t   rx_stb_bit_sel,
  input  wire ca_rx_align_pkg::ch_data_t [ca_rx_align_pkg::NUM_CHANNELS-1:0] rx_din,
  output ca_rx_align_pkg::ch_data_t [ca_rx_align_pkg::NUM_CHANNELS-1:0]      rx_dout,
  output logic                             align_done,
  output logic                             align_err,
  output logic                             rx_stb_pos_err,
  output logic                             rx_stb_pos_coding_err,
  output logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] fifo_full,
  output logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] fifo_empty
);

  ca_rx_align_pkg::stb_pattern_t stb_pattern;
  ca_rx_align_pkg::lane_status_t [ca_rx_align_pkg::NUM_CHANNELS-1:0] lane_status;
  logic                          online;
  logic                          fifo_pop;

  ca_rx_stb_sel stb_sel_i (
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .stb_pattern           (stb_pattern),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err),
    .rx_stb_pos_err        (rx_stb_pos_err)
  );

  // Lane 0 in the low word of rx_din and rx_dout
  for (genvar i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
  begin : g_lane
    ca_rx_lane lane_i (
      .com_clk     (com_clk),
      .rst_com_n   (rst_com_n),
      .online      (online),
      .stb_pattern (stb_pattern),
      .fifo_pop    (fifo_pop),
      .rx_din      (rx_din[i]),
      .rx_dout     (rx_dout[i]),
      .status      (lane_status[i]),
      .fifo_full   (fifo_full[i]),
      .fifo_empty  (fifo_empty[i])
    );
  end

  ca_rx_align_ctrl ctrl_i (
    .com_clk     (com_clk),
    .rst_com_n   (rst_com_n),
    .rx_online   (rx_online),
    .rden_dly    (rden_dly),
    .lane_status (lane_status),
    .online      (online),
    .fifo_pop    (fifo_pop),
    .align_done  (align_done),
    .align_err   (align_err)
  );

endmodule

`default_nettype wire

/* test/ca_rx_align_checker.sv */
// Strobe select model, lane strobe tracking and per-session checks of the aligner outputs
`timescale 1ns/1ns
`default_nettype none

module ca_rx_align_checker
(
  input  wire                                 com_clk,
  input  wire                                 rst_com_n,
  input  wire                                 rx_online,
  input  wire ca_rx_align_pkg::rd_dly_t       rden_dly,
  input  wire ca_rx_align_pkg::wd_sel_t       rx_stb_wd_sel,
  input  wire ca_rx_align_pkg::bit_sel_t      rx_stb_bit_sel,
  input  wire ca_rx_align_pkg::ch_data_t [ca_rx_align_pkg::NUM_CHANNELS-1:0] rx_din,
  input  wire ca_rx_align_pkg::ch_data_t [ca_rx_align_pkg::NUM_CHANNELS-1:0] rx_dout,
  input  wire                                 align_done,
  input  wire                                 align_err,
  input  wire                                 rx_stb_pos_err,
  input  wire                                 rx_stb_pos_coding_err,
  input  wire [ca_rx_align_pkg::NUM_CHANNELS-1:0] fifo_full,
  input  wire [ca_rx_align_pkg::NUM_CHANNELS-1:0] fifo_empty,
  output int                                  check_count,
  output int                                  error_count
);

  int   loc;            // Model strobe location
  int   stb_cyc [ca_rx_align_pkg::NUM_CHANNELS];   // -1 until the lane strobe shows
  bit   full_seen [ca_rx_align_pkg::NUM_CHANNELS];
  bit   in_session;
  bit   err_seen;
  bit   done_prev;
  bit   reset_checked;
  int   session_cycle;
  int   done_rises;
  int   off_cycles;
  int   dly;            // Read delay of the session
  logic exp_pos_err;
  logic exp_coding_err;

  // Lowest word bit picks the word, highest set bit gives the position
  function automatic void model_sel(input ca_rx_align_pkg::wd_sel_t wd,
                                    input ca_rx_align_pkg::bit_sel_t bs, output int l,
                                    output logic pos_err, output logic coding_err);
    int word;
    int pos;
    word = 0;
    if (wd != '0)
      while (!wd[word])
        word++;
    pos = ca_rx_align_pkg::WORD_BITS - 1;
    while (pos > 0 && !bs[pos])
      pos--;
    l          = word * ca_rx_align_pkg::WORD_BITS + pos;
    pos_err    = l > ca_rx_align_pkg::BITS_PER_CHANNEL;
    coding_err = ($countones(wd) != 1) || ($countones(bs) != 1);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act)
    begin
      error_count++;
      $display("error t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Session tracking
  //////////////////////////////////////////////////////////////////////

  task automatic track_online();
    int late;
    int exp_seq;
    if (!in_session)
    begin
      in_session    = 1;
      session_cycle = 0;
      err_seen      = 0;
      done_rises    = 0;
      dly           = rden_dly;
      stb_cyc       = '{default: -1};
      full_seen     = '{default: 0};
    end
    session_cycle++;
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
    begin
      if (stb_cyc[i] < 0 && loc < ca_rx_align_pkg::BITS_PER_CHANNEL && rx_din[i][loc])
        stb_cyc[i] = session_cycle;
      if (!err_seen && fifo_full[i])
        full_seen[i] = 1;   // Full before the error
    end
    err_seen = err_seen | align_err;
    if (align_done && !done_prev)
      done_rises++;
    if (align_done)
    begin
      late = stb_cyc[0];
      for (int i = 1; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
        if (stb_cyc[i] > late)
          late = stb_cyc[i];
      // First pop two cycles after the late strobe plus the read delay
      // Sequence 2 shows the cycle after that pop
      exp_seq = session_cycle - (late + 2 + dly) + 1;
      for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
        check_val($sformatf("rx_dout[%0d] sequence", i), exp_seq, rx_dout[i][79:64]);
    end
  endtask

  // Lane ahead by FIFO_DEPTH-1 or more overflows before the late first_stb
  task automatic close_session();
    int early;
    int gap;
    early = 0;
    gap   = 0;
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
    begin
      if (stb_cyc[i] < 0)
      begin
        error_count++;
        $display("t=%0t lane %0d showed no strobe while online", $time, i);
        return;
      end
      if (stb_cyc[i] < stb_cyc[early])
        early = i;
    end
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
      if (stb_cyc[i] - stb_cyc[early] > gap)
        gap = stb_cyc[i] - stb_cyc[early];
    if (gap >= ca_rx_align_pkg::FIFO_DEPTH - 1)
    begin
      check_val("align_err seen", 1, err_seen);
      check_val("align_done rises", 0, done_rises);
      check_val("fifo_full early lane before align_err", 1, full_seen[early]);
    end
    else
    begin
      check_val("align_done rises", 1, done_rises);
      check_val("align_err seen", 0, err_seen);
    end
  endtask

  always @(posedge com_clk)
  begin
    if (!rst_com_n)
    begin
      check_count   = 0;
      error_count   = 0;
      in_session    = 0;
      done_prev     = 0;
      reset_checked = 0;
      off_cycles    = 0;
    end
    else
    begin
      if (!reset_checked)
      begin
        check_val("align_done", 0, align_done);
        check_val("align_err", 0, align_err);
        check_val("fifo_empty", {ca_rx_align_pkg::NUM_CHANNELS{1'b1}}, fifo_empty);
        reset_checked = 1;
      end
      model_sel(rx_stb_wd_sel, rx_stb_bit_sel, loc, exp_pos_err, exp_coding_err);
      check_val("rx_stb_pos_err", exp_pos_err, rx_stb_pos_err);
      check_val("rx_stb_pos_coding_err", exp_coding_err, rx_stb_pos_coding_err);
      if (rx_online)
        track_online();
      else
      begin
        if (in_session)
        begin
          close_session();
          in_session = 0;
          off_cycles = 0;
        end
        off_cycles++;
        if (off_cycles == 3)   // Two cycles after rx_online fell
        begin
          check_val("align_done", 0, align_done);
          check_val("align_err", 0, align_err);
          check_val("fifo_empty", {ca_rx_align_pkg::NUM_CHANNELS{1'b1}}, fifo_empty);
        end
      end
      done_prev = align_done;
    end
  end

endmodule

`default_nettype wire

/* test/tb_ca_rx_align.sv */
// Clock, reset, random lane stimulus, DUT and checker instances, run control
`timescale 1ns/1ns
`default_nettype none

module tb_ca_rx_align;

  localparam int NC          = ca_rx_align_pkg::NUM_CHANNELS;
  localparam int RST_CYCLES  = 16;
  localparam int CYCLE_LIMIT = 6 * 150 + RST_CYCLES + 100;  // Six scenarios, reset, margin

  logic                               com_clk;
  logic                               rst_com_n;
  logic                               rx_online;
  ca_rx_align_pkg::rd_dly_t           rden_dly;
  ca_rx_align_pkg::wd_sel_t           rx_stb_wd_sel;
  ca_rx_align_pkg::bit_sel_t          rx_stb_bit_sel;
  ca_rx_align_pkg::ch_data_t [NC-1:0] rx_din;
  ca_rx_align_pkg::ch_data_t [NC-1:0] rx_dout;
  logic                               align_done;
  logic                               align_err;
  logic                               rx_stb_pos_err;
  logic                               rx_stb_pos_coding_err;
  logic [NC-1:0]                      fifo_full;
  logic [NC-1:0]                      fifo_empty;
  int                                 check_count;
  int                                 error_count;
  int unsigned                        cycle_cnt;
  int unsigned                        stb_loc;      // Strobe bit inside the lane word
  int unsigned                        skew [NC];
  int unsigned                        seq_num [NC];

  ca_rx_align dut_i (.*);

  ca_rx_align_checker checker_i (.*);

  initial
  begin
    com_clk = 1'b0;
    forever #10 com_clk = ~com_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Sequence number in the top 16 bits, only sequence 1 carries the strobe
  task automatic drive_lanes(input int unsigned cyc);
    for (int i = 0; i < NC; i++)
    begin
      if (rx_online && cyc > skew[i])
        seq_num[i]++;
      else
        seq_num[i] = 0;
      rx_din[i][63:0]    = {$urandom, $urandom};
      rx_din[i][79:64]   = 16'(seq_num[i]);
      rx_din[i][stb_loc] = seq_num[i] == 1;
    end
  endtask

  task automatic sweep_selects(input int n);
    repeat (n)
    begin
      @(negedge com_clk);
      rx_stb_wd_sel  = ca_rx_align_pkg::wd_sel_t'(1) << ($urandom % 8);
      rx_stb_bit_sel = ca_rx_align_pkg::bit_sel_t'(1) << ($urandom % 40);
      case ($urandom % 5)
        0:       rx_stb_wd_sel  = '0;
        1:       rx_stb_bit_sel = '0;
        2:       rx_stb_wd_sel  = rx_stb_wd_sel | 8'($urandom);  // Likely several bits
        3:       rx_stb_bit_sel = rx_stb_bit_sel | 40'({$urandom, $urandom});
        default: ;
      endcase
      drive_lanes(0);
    end
  endtask

  task automatic go_offline(input int n);
    repeat (n)
    begin
      @(negedge com_clk);
      rx_online = 1'b0;
      drive_lanes(0);
    end
  endtask

  // One online period, the late lane runs past the FIFO depth in the overflow case
  task automatic run_session(input bit overflow);
    int unsigned word;
    int unsigned late;
    int unsigned cyc;
    word = $urandom % 2;
    late = $urandom % NC;
    @(negedge com_clk);
    stb_loc        = word * 40 + $urandom % (word == 0 ? 40 : 24);  // Below the sequence field
    rx_stb_wd_sel  = ca_rx_align_pkg::wd_sel_t'(1) << word;
    rx_stb_bit_sel = ca_rx_align_pkg::bit_sel_t'(1) << (stb_loc % 40);
    rden_dly       = ca_rx_align_pkg::rd_dly_t'($urandom % 8);
    for (int i = 0; i < NC; i++)
      skew[i] = overflow ? ((i == late) ? 20 : 0) : $urandom % 7;
    rx_online = 1'b1;
    cyc = 0;
    drive_lanes(cyc);
    while (!align_done && !align_err && cyc < 100)
    begin
      @(negedge com_clk);
      cyc++;
      drive_lanes(cyc);
    end
    repeat (20)
    begin
      @(negedge com_clk);
      cyc++;
      drive_lanes(cyc);
    end
    go_offline(8);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h620c_e6b8));
    rst_com_n      = 1'b0;
    rx_online      = 1'b0;
    rden_dly       = '0;
    rx_stb_wd_sel  = 8'h01;
    rx_stb_bit_sel = 40'h1;
    rx_din         = '0;
    stb_loc        = 0;
    skew           = '{default: 0};
    seq_num        = '{default: 0};
    repeat (RST_CYCLES) @(posedge com_clk);
    @(negedge com_clk);
    rst_com_n = 1'b1;
    go_offline(4);
    sweep_selects(100);
    run_session(1'b0);
    run_session(1'b0);
    run_session(1'b1);   // Overflow
    run_session(1'b0);   // Restart after the error
    run_session(1'b0);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge com_clk);
      cycle_cnt++;
    end
    $display("Run stopped, the scenarios did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* ca_rx_align.f */
verilog/ca_rx_align_pkg.sv
verilog/ca_rx_align_fifo.sv
verilog/ca_rx_lane.sv
verilog/ca_rx_stb_sel.sv
verilog/ca_rx_align_ctrl.sv
verilog/ca_rx_align.sv
test/ca_rx_align_checker.sv
test/tb_ca_rx_align.sv

/* Makefile */
TOP = tb_ca_rx_align

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f ca_rx_align.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
